// File: list.f
verilog/fir_pkg.sv
verilog/fir_sample_fifo.sv
verilog/fir_coeff_bank.sv
verilog/fir_datapath.sv
verilog/fir_wb_regs.sv
verilog/fir_top.sv
test/fir_props.sv
test/tb_fir_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the FIR testbench with Verilator, runs it and checks the outcome.
# Exits non-zero on a build error, a simulator error or a failing test.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_fir_top -f list.f -o sim_fir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_fir +verilator+error+limit+1000 > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi

if grep -q "Errors found" "$SIM_LOG"; then
	exit 1
fi
exit 0

// File: test/fir_props.sv
//////////////////////////////
// Wishbone and FIFO protocol assertions, bound to the FIR top level.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fir_props (
	input wire              clock,
	input wire              arst_n,
	input fir_pkg::wb_req_t wb_req,
	input fir_pkg::wb_rsp_t wb_rsp,
	input wire              in_push,
	input wire              in_full,
	input wire              in_pop,
	input wire              in_empty,
	input wire              out_push,
	input wire              out_full,
	input wire              out_pop,
	input wire              out_empty
);
	// Number of assertion failures, read by the testbench at the end of the run.
	int violations = 0;

	// The slave may only acknowledge an access that the master still holds.
	ack_in_cycle: assert property (@(posedge clock) disable iff (!arst_n)
		wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
		else begin
			violations = violations + 1;
			$error("ack raised outside an active bus cycle");
		end

	// Every ack is a single-cycle pulse.
	ack_single: assert property (@(posedge clock) disable iff (!arst_n)
		wb_rsp.ack |=> !wb_rsp.ack)
		else begin
			violations = violations + 1;
			$error("ack held high for two cycles");
		end

	// While reset is applied the bus stays quiet.
	ack_reset: assert property (@(posedge clock) !arst_n |-> !wb_rsp.ack)
		else begin
			violations = violations + 1;
			$error("ack high during reset");
		end

	// Neither FIFO is ever pushed when full or popped when empty.
	fifo_push_ok: assert property (@(posedge clock) disable iff (!arst_n)
		!(in_push && in_full) && !(out_push && out_full))
		else begin
			violations = violations + 1;
			$error("push into a full FIFO");
		end

	fifo_pop_ok: assert property (@(posedge clock) disable iff (!arst_n)
		!(in_pop && in_empty) && !(out_pop && out_empty))
		else begin
			violations = violations + 1;
			$error("pop from an empty FIFO");
		end

endmodule

bind fir_top fir_props i_props (
	.clock     (clock),
	.arst_n    (arst_n),
	.wb_req    (wb_req),
	.wb_rsp    (wb_rsp),
	.in_push   (in_push),
	.in_full   (in_full),
	.in_pop    (in_pop),
	.in_empty  (in_empty),
	.out_push  (out_push),
	.out_full  (out_full),
	.out_pop   (out_pop),
	.out_empty (out_empty)
);

`default_nettype wire

// File: test/tb_fir_top.sv
//////////////////////////////
// Testbench for the FIR subsystem, driven over Wishbone.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_fir_top;
	import fir_pkg::*;

	localparam int clock_period = 10;
	// The six tests make about 290 bus accesses. The budget is rounded up.
	localparam int bus_accesses    = 320;
	localparam int watchdog_cycles = bus_accesses * 20 + 1000;

	logic        clock;
	logic        arst_n;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	logic [15:0] lfsr;
	int          errors;

	// Software model of the filter. Index 0 of the line is the newest sample.
	sample_t model_line [taps];
	coeff_t  model_coeffs [taps];
	int      expected_q [$];

	fir_top i_fir_top (
		.clock  (clock),
		.arst_n (arst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	always #(clock_period / 2) clock = ~clock;

	// 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	// One LFSR step per bit taken.
	task automatic rand_byte(output logic [7:0] value);
		value = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr  = lfsr_next(lfsr);
			value = {value[6:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input string what, input int expected, input int actual);
		assert (actual == expected) else begin
			$display("CHECK FAILED at %0t ns: %s expected %0d, actual %0d",
				$time, what, expected, actual);
			errors++;
		end
	endtask

	// One classic cycle. Starts and ends 1 ns after a rising edge.
	// The request is held through the edge that samples ack.
	task automatic bus_access(input logic we, input logic [wb_aw-1:0] adr,
		input logic [wb_dw-1:0] wdat, output logic [wb_dw-1:0] rdat);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		do begin
			@(posedge clock);
			#1;
		end while (!wb_rsp.ack);
		rdat = wb_rsp.dat;
		@(posedge clock);
		#1;
		wb_req = '0;
	endtask

	task automatic bus_write(input logic [wb_aw-1:0] adr, input logic [wb_dw-1:0] wdat);
		logic [wb_dw-1:0] unused;
		bus_access(1'b1, adr, wdat, unused);
	endtask

	task automatic bus_read(input logic [wb_aw-1:0] adr, output logic [wb_dw-1:0] rdat);
		bus_access(1'b0, adr, '0, rdat);
	endtask

	// A write that gives up after max_cycles without ack and withdraws the strobe.
	task automatic try_write(input logic [wb_aw-1:0] adr, input logic [wb_dw-1:0] wdat,
		input int max_cycles, output bit acked);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = 1'b1;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		acked = 1'b0;
		for (int i = 0; i < max_cycles && !acked; i++) begin
			@(posedge clock);
			#1;
			acked = wb_rsp.ack;
		end
		if (acked) begin
			@(posedge clock);
			#1;
		end
		wb_req = '0;
	endtask

	task automatic read_status(output int mode_v, output int in_v, output int out_v);
		logic [wb_dw-1:0] stat;
		bus_read(reg_status, stat);
		mode_v = int'(stat[1:0]);
		in_v   = int'(stat[stat_in_lsb +: cnt_w]);
		out_v  = int'(stat[stat_out_lsb +: cnt_w]);
	endtask

	task automatic model_clear();
		for (int i = 0; i < taps; i++) begin
			model_line[i] = '0;
		end
	endtask

	// Exact convolution. Eight products of two 8-bit values always fit in acc_w bits.
	task automatic model_push(input sample_t x);
		int sum;
		for (int i = taps - 1; i > 0; i--) begin
			model_line[i] = model_line[i-1];
		end
		model_line[0] = x;
		sum = 0;
		for (int i = 0; i < taps; i++) begin
			sum += int'(model_coeffs[i]) * int'(model_line[i]);
		end
		expected_q.push_back(sum);
	endtask

	// Writes taps coefficients in Load. The first one can be forced to -128.
	task automatic write_coeffs(input bit force_min);
		logic [7:0] rnd;
		coeff_t     c;
		for (int i = 0; i < taps; i++) begin
			rand_byte(rnd);
			c = (force_min && i == 0) ? coeff_t'(-128) : coeff_t'(rnd);
			model_coeffs[i] = c;
			bus_write(reg_coeff, wb_dw'(c));
		end
	endtask

	task automatic load_coeffs(input bit force_min);
		bus_write(reg_ctrl, wb_dw'(1 << ctrl_load));
		model_clear();
		write_coeffs(force_min);
	endtask

	task automatic stop_restart();
		bus_write(reg_ctrl, wb_dw'(1 << ctrl_stop));
		bus_write(reg_ctrl, wb_dw'(1 << ctrl_restart));
		model_clear();
	endtask

	task automatic run_sample(input sample_t x);
		bus_write(reg_sample, wb_dw'(x));
		model_push(x);
	endtask

	// Polls the output count, then pops one result and compares it with the model.
	task automatic read_result();
		int               mode_v;
		int               in_v;
		int               out_v;
		logic [wb_dw-1:0] rdat;
		do begin
			read_status(mode_v, in_v, out_v);
		end while (out_v == 0);
		bus_read(reg_result, rdat);
		if (expected_q.size() == 0) begin
			$display("A result was read while the model expected none");
			errors++;
		end else begin
			check_value("wb_rsp.dat result", expected_q.pop_front(), int'($signed(rdat)));
		end
	endtask

	initial begin
		#(watchdog_cycles * clock_period);
		$display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
		$display("Errors found");
		$finish;
	end

	initial begin
		logic [wb_dw-1:0] rdat;
		logic [7:0]       rnd;
		int               mode_v;
		int               in_v;
		int               out_v;
		int               total;
		bit               acked;
		clock  = 1'b0;
		arst_n = 1'b0;
		wb_req = '0;
		errors = 0;
		lfsr   = 16'd35096;
		model_clear();
		repeat (3) @(posedge clock);
		#1;
		arst_n = 1'b1;

		// Mode sequence Idle, Load, Run, Stop and back to Idle.
		read_status(mode_v, in_v, out_v);
		check_value("status mode after reset", int'(mode_idle), mode_v);
		check_value("status in count after reset", 0, in_v);
		check_value("status out count after reset", 0, out_v);
		bus_write(reg_ctrl, wb_dw'(1 << ctrl_load));
		read_status(mode_v, in_v, out_v);
		check_value("status mode after load", int'(mode_load), mode_v);
		write_coeffs(1'b0);
		read_status(mode_v, in_v, out_v);
		check_value("status mode after coefficients", int'(mode_run), mode_v);
		bus_write(reg_ctrl, wb_dw'(1 << ctrl_stop));
		read_status(mode_v, in_v, out_v);
		check_value("status mode after stop", int'(mode_stop), mode_v);
		bus_write(reg_ctrl, wb_dw'(1 << ctrl_restart));
		read_status(mode_v, in_v, out_v);
		check_value("status mode after restart", int'(mode_idle), mode_v);

		// An impulse returns the coefficients in write order.
		load_coeffs(1'b0);
		for (int k = 0; k < taps; k++) begin
			run_sample((k == 0) ? sample_t'(1) : sample_t'(0));
			read_result();
		end
		stop_restart();

		// Random convolution with -128 in the first coefficient and every tenth sample.
		load_coeffs(1'b1);
		for (int k = 0; k < 30; k++) begin
			rand_byte(rnd);
			run_sample((k % 10 == 0) ? sample_t'(-128) : sample_t'(rnd));
			read_result();
		end

		// Back-pressure. Eight samples fill both FIFOs and the next write must stall.
		for (int k = 0; k < 2 * fifo_depth; k++) begin
			rand_byte(rnd);
			run_sample(sample_t'(rnd));
		end
		read_status(mode_v, in_v, out_v);
		check_value("status in count when full", fifo_depth, in_v);
		check_value("status out count when full", fifo_depth, out_v);
		try_write(reg_sample, wb_dw'(8'h3c), 12, acked);
		check_value("wb_rsp.ack on write to full FIFO", 0, int'(acked));
		for (int k = 0; k < 2 * fifo_depth; k++) begin
			read_result();
		end
		for (int k = 0; k < 2; k++) begin
			rand_byte(rnd);
			run_sample(sample_t'(rnd));
			read_result();
		end

		// Mode gating. A coefficient in Run is dropped and an empty result reads zero.
		rand_byte(rnd);
		bus_write(reg_coeff, wb_dw'(rnd));
		rand_byte(rnd);
		run_sample(sample_t'(rnd));
		read_result();
		bus_read(reg_result, rdat);
		check_value("wb_rsp.dat from empty result FIFO", 0, int'(rdat));
		stop_restart();
		bus_write(reg_sample, wb_dw'(8'h55));
		read_status(mode_v, in_v, out_v);
		check_value("status in count after Idle sample", 0, in_v);
		check_value("status out count after Idle sample", 0, out_v);

		// Restart clears history, so the new run sees zeros before its first sample.
		load_coeffs(1'b0);
		for (int k = 0; k < 10; k++) begin
			rand_byte(rnd);
			run_sample(sample_t'(rnd));
			read_result();
		end
		check_value("results never read", 0, expected_q.size());

		total = errors + i_fir_top.i_props.violations;
		$display("Summary: %0d check errors, %0d protocol assertion failures",
			errors, i_fir_top.i_props.violations);
		if (total == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/fir_coeff_bank.sv
//////////////////////////////
// Coefficient shift register with a load counter and full flag.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fir_coeff_bank (
	input  wire             clock,
	input  wire             arst_n,
	input  wire             clear,
	input  wire             push,
	input  fir_pkg::coeff_t coeff_in,
	output fir_pkg::coeff_t coeffs [fir_pkg::taps],
	output logic            full
);
	import fir_pkg::*;

	coeff_t               bank_q [taps];
	logic [tap_cnt_w-1:0] count_q;

	// The bank is full once taps coefficients have gone in since the last clear.
	assign full = (count_q == tap_cnt_w'(taps));

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			count_q <= '0;
			for (int i = 0; i < taps; i++) begin
				bank_q[i] <= '0;
			end
		end else if (clear) begin
			count_q <= '0;
			for (int i = 0; i < taps; i++) begin
				bank_q[i] <= '0;
			end
		end else if (push && !full) begin
			// Shift one place and insert at the head.
			// The first coefficient written ends up in the last slot.
			for (int i = taps - 1; i > 0; i--) begin
				bank_q[i] <= bank_q[i-1];
			end
			bank_q[0] <= coeff_in;
			count_q   <= count_q + 1'b1;
		end
	end

	assign coeffs = bank_q;

endmodule

`default_nettype wire

// File: verilog/fir_datapath.sv
//////////////////////////////
// FIR delay line and two-stage multiply-accumulate pipeline with credit control.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fir_datapath (
	input  wire                      clock,
	input  wire                      arst_n,
	input  wire                      line_clear,
	input  fir_pkg::fir_mode_t       mode,
	input  fir_pkg::coeff_t          coeffs [fir_pkg::taps],
	input  wire                      in_empty,
	input  fir_pkg::sample_t         in_data,
	output logic                     in_pop,
	input  wire [fir_pkg::cnt_w-1:0] out_count,
	output logic                     out_push,
	output fir_pkg::acc_t            out_data
);
	import fir_pkg::*;

	sample_t    line_q    [taps];
	sample_t    line_next [taps];
	prod_t      prod_d    [taps];
	prod_t      prod_q    [taps];
	acc_t       sum_d;
	acc_t       sum_q;
	logic       s1_valid;
	logic       s2_valid;
	logic [1:0] in_flight;
	logic       credit_ok;

	// Every sample in the pipeline already owns an output FIFO slot.
	// A pop is only allowed while a free slot remains for it.
	assign in_flight = {1'b0, s1_valid} + {1'b0, s2_valid};
	assign credit_ok = (out_count + cnt_w'(in_flight)) < cnt_w'(fifo_depth);
	assign in_pop    = !in_empty && (mode == mode_run) && credit_ok;

	// The delay line as it looks after the popped sample has been shifted in.
	// The newest sample meets the coefficient that was written first.
	always_comb begin
		line_next[0] = in_data;
		for (int i = 1; i < taps; i++) begin
			line_next[i] = line_q[i-1];
		end
		for (int i = 0; i < taps; i++) begin
			prod_d[i] = line_next[i] * coeffs[taps-1-i];
		end
	end

	// Sum of the registered products. Each term is sign-extended first.
	always_comb begin
		sum_d = '0;
		for (int i = 0; i < taps; i++) begin
			sum_d = sum_d + acc_t'(prod_q[i]);
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			for (int i = 0; i < taps; i++) begin
				line_q[i] <= '0;
			end
		end else begin
			// Clears only come outside Run, so they never meet a pop.
			if (line_clear) begin
				for (int i = 0; i < taps; i++) begin
					line_q[i] <= '0;
				end
			end else if (in_pop) begin
				line_q <= line_next;
			end
			s1_valid <= in_pop;
			s2_valid <= s1_valid;
		end
	end

	// Stage 1 holds the products, stage 2 the sum.
	always_ff @(posedge clock) begin
		if (in_pop) begin
			prod_q <= prod_d;
		end
		if (s1_valid) begin
			sum_q <= sum_d;
		end
	end

	// Push two cycles after the pop.
	assign out_push = s2_valid;
	assign out_data = sum_q;

endmodule

`default_nettype wire

// File: verilog/fir_pkg.sv
//////////////////////////////
// FIR filter shared definitions. Sizes, register map, modes and bus structs.
//////////////////////////////
`default_nettype none

package fir_pkg;

	// Filter geometry. The result width is sample_w + coeff_w + log2(taps).
	localparam int taps       = 8;
	localparam int sample_w   = 8;
	localparam int coeff_w    = 8;
	localparam int prod_w     = sample_w + coeff_w;
	localparam int acc_w      = 19;
	localparam int tap_cnt_w  = $clog2(taps + 1);

	// Both FIFOs share one depth. The count needs one bit more than the pointers.
	localparam int fifo_depth = 4;
	localparam int fifo_ptr_w = $clog2(fifo_depth);
	localparam int cnt_w      = $clog2(fifo_depth + 1);

	// Wishbone data width and word address width.
	localparam int wb_dw = 32;
	localparam int wb_aw = 3;

	// Register map, as word addresses.
	localparam logic [wb_aw-1:0] reg_ctrl   = 3'd0;
	localparam logic [wb_aw-1:0] reg_coeff  = 3'd1;
	localparam logic [wb_aw-1:0] reg_sample = 3'd2;
	localparam logic [wb_aw-1:0] reg_result = 3'd3;
	localparam logic [wb_aw-1:0] reg_status = 3'd4;

	// Control command bits and status field positions.
	localparam int ctrl_load    = 0;
	localparam int ctrl_stop    = 1;
	localparam int ctrl_restart = 2;
	localparam int stat_in_lsb  = 4;
	localparam int stat_out_lsb = 8;

	typedef logic signed [sample_w-1:0] sample_t;
	typedef logic signed [coeff_w-1:0]  coeff_t;
	typedef logic signed [prod_w-1:0]   prod_t;
	typedef logic signed [acc_w-1:0]    acc_t;

	typedef enum logic [1:0] {
		mode_idle = 2'd0,
		mode_load = 2'd1,
		mode_run  = 2'd2,
		mode_stop = 2'd3
	} fir_mode_t;

	// Master to slave. Held stable by the master until ack.
	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [wb_aw-1:0] adr;
		logic [wb_dw-1:0] dat;
	} wb_req_t;

	// Slave to master.
	typedef struct packed {
		logic             ack;
		logic [wb_dw-1:0] dat;
	} wb_rsp_t;

endpackage

`default_nettype wire

// File: verilog/fir_sample_fifo.sv
//////////////////////////////
// Synchronous FIFO with a type-parameterized payload.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fir_sample_fifo #(
	parameter type payload_t = fir_pkg::sample_t
) (
	input  wire                      clock,
	input  wire                      arst_n,
	input  wire                      push,
	input  wire                      pop,
	input  payload_t                 push_data,
	output payload_t                 pop_data,
	output logic                     full,
	output logic                     empty,
	output logic [fir_pkg::cnt_w-1:0] count
);
	import fir_pkg::*;

	payload_t              mem [fifo_depth];
	logic [fifo_ptr_w-1:0] wr_ptr_q;
	logic [fifo_ptr_w-1:0] rd_ptr_q;
	logic [cnt_w-1:0]      count_q;
	logic                  wr_en;
	logic                  rd_en;

	assign full  = (count_q == cnt_w'(fifo_depth));
	assign empty = (count_q == '0);
	assign count = count_q;

	// Requests against a full or empty FIFO are dropped here as well.
	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	// The head entry is always presented.
	assign pop_data = mem[rd_ptr_q];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			// Pointers wrap naturally since the depth is a power of two.
			if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;
			if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_ptr_q] <= push_data;
		end
	end

endmodule

`default_nettype wire

// File: verilog/fir_top.sv
//////////////////////////////
// FIR filter subsystem behind a Wishbone classic slave.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fir_top (
	input  wire              clock,
	input  wire              arst_n,
	input  fir_pkg::wb_req_t wb_req,
	output fir_pkg::wb_rsp_t wb_rsp
);
	import fir_pkg::*;

	// Register block to coefficient bank.
	logic             coeff_push;
	coeff_t           coeff_data;
	logic             bank_clear;
	logic             bank_full;
	coeff_t           coeffs [taps];

	// Control towards the datapath.
	logic             line_clear;
	fir_mode_t        mode;

	// Input FIFO, written by the bus and read by the datapath.
	logic             in_push;
	sample_t          in_data;
	logic             in_pop;
	sample_t          in_head;
	logic             in_full;
	logic             in_empty;
	logic [cnt_w-1:0] in_count;

	// Output FIFO, written by the datapath and read by the bus.
	logic             out_push;
	acc_t             out_result;
	logic             out_pop;
	acc_t             out_head;
	logic             out_full;
	logic             out_empty;
	logic [cnt_w-1:0] out_count;

	fir_wb_regs i_regs (
		.clock      (clock),
		.arst_n     (arst_n),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.bank_full  (bank_full),
		.coeff_push (coeff_push),
		.coeff_data (coeff_data),
		.bank_clear (bank_clear),
		.line_clear (line_clear),
		.mode       (mode),
		.in_push    (in_push),
		.in_data    (in_data),
		.in_full    (in_full),
		.in_count   (in_count),
		.out_pop    (out_pop),
		.out_data   (out_head),
		.out_empty  (out_empty),
		.out_count  (out_count)
	);

	fir_coeff_bank i_coeff_bank (
		.clock    (clock),
		.arst_n   (arst_n),
		.clear    (bank_clear),
		.push     (coeff_push),
		.coeff_in (coeff_data),
		.coeffs   (coeffs),
		.full     (bank_full)
	);

	fir_sample_fifo #(.payload_t(sample_t)) i_in_fifo (
		.clock     (clock),
		.arst_n    (arst_n),
		.push      (in_push),
		.pop       (in_pop),
		.push_data (in_data),
		.pop_data  (in_head),
		.full      (in_full),
		.empty     (in_empty),
		.count     (in_count)
	);

	fir_datapath i_datapath (
		.clock      (clock),
		.arst_n     (arst_n),
		.line_clear (line_clear),
		.mode       (mode),
		.coeffs     (coeffs),
		.in_empty   (in_empty),
		.in_data    (in_head),
		.in_pop     (in_pop),
		.out_count  (out_count),
		.out_push   (out_push),
		.out_data   (out_result)
	);

	// The datapath credit keeps this FIFO from overflowing.
	fir_sample_fifo #(.payload_t(acc_t)) i_out_fifo (
		.clock     (clock),
		.arst_n    (arst_n),
		.push      (out_push),
		.pop       (out_pop),
		.push_data (out_result),
		.pop_data  (out_head),
		.full      (out_full),
		.empty     (out_empty),
		.count     (out_count)
	);

endmodule

`default_nettype wire

// File: verilog/fir_wb_regs.sv
//////////////////////////////
// Wishbone register block and the Idle/Load/Run/Stop mode FSM of the FIR.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fir_wb_regs (
	input  wire                            clock,
	input  wire                            arst_n,
	input  fir_pkg::wb_req_t               wb_req,
	output fir_pkg::wb_rsp_t               wb_rsp,
	input  wire                            bank_full,
	output logic                           coeff_push,
	output fir_pkg::coeff_t                coeff_data,
	output logic                           bank_clear,
	output logic                           line_clear,
	output fir_pkg::fir_mode_t             mode,
	output logic                           in_push,
	output fir_pkg::sample_t               in_data,
	input  wire                            in_full,
	input  wire [fir_pkg::cnt_w-1:0]       in_count,
	output logic                           out_pop,
	input  fir_pkg::acc_t                  out_data,
	input  wire                            out_empty,
	input  wire [fir_pkg::cnt_w-1:0]       out_count
);
	import fir_pkg::*;

	fir_mode_t        mode_q;
	logic             ack_q;
	logic [wb_dw-1:0] rdata_q;
	logic [wb_dw-1:0] rdata_d;
	logic             access;
	logic             wr;
	logic             rd;
	logic             ctrl_wr;
	logic             sample_wr;
	logic             stall;
	logic             load_cmd;
	logic             stop_cmd;
	logic             restart_cmd;

	// A new access is a strobe that has not been acknowledged yet.
	// The ack cycle itself never counts, so each access acts once.
	assign access = wb_req.cyc && wb_req.stb && !ack_q;
	assign wr     = access && wb_req.we;
	assign rd     = access && !wb_req.we;

	assign ctrl_wr   = wr && (wb_req.adr == reg_ctrl);
	assign sample_wr = wr && (wb_req.adr == reg_sample) && (mode_q == mode_run);

	// A sample write in Run holds off its ack until the input FIFO has room.
	assign stall   = sample_wr && in_full;
	assign in_push = sample_wr && !in_full;
	assign in_data = wb_req.dat[sample_w-1:0];

	// Coefficients are only taken in Load, and never once the bank is full.
	assign coeff_push = wr && (wb_req.adr == reg_coeff) && (mode_q == mode_load) && !bank_full;
	assign coeff_data = wb_req.dat[coeff_w-1:0];

	// Commands only act in the mode they belong to. Others are ignored.
	assign load_cmd    = ctrl_wr && wb_req.dat[ctrl_load] && (mode_q == mode_idle);
	assign stop_cmd    = ctrl_wr && wb_req.dat[ctrl_stop] && (mode_q == mode_run);
	assign restart_cmd = ctrl_wr && wb_req.dat[ctrl_restart] && (mode_q == mode_stop);

	// A new load wipes the bank and the sample history. A restart only wipes the history.
	assign bank_clear = load_cmd;
	assign line_clear = load_cmd || restart_cmd;

	// The head of the output FIFO is captured into the read data on the same edge it is popped.
	assign out_pop = rd && (wb_req.adr == reg_result) && !out_empty;

	always_comb begin
		rdata_d = '0;
		case (wb_req.adr)
			reg_ctrl: rdata_d[1:0] = mode_q;
			reg_result: begin
				// Results are sign-extended to the bus width. An empty FIFO reads as zero.
				if (!out_empty) begin
					rdata_d = wb_dw'(out_data);
				end
			end
			reg_status: begin
				rdata_d[1:0]                  = mode_q;
				rdata_d[stat_in_lsb +: cnt_w]  = in_count;
				rdata_d[stat_out_lsb +: cnt_w] = out_count;
			end
			default: rdata_d = '0;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			ack_q  <= 1'b0;
			mode_q <= mode_idle;
		end else begin
			// Ack follows the strobe by one cycle unless the access is stalled.
			ack_q <= access && !stall;
			case (mode_q)
				mode_idle: if (load_cmd) mode_q <= mode_load;
				// Run starts the cycle after the eighth coefficient sets bank_full.
				mode_load: if (bank_full) mode_q <= mode_run;
				mode_run:  if (stop_cmd) mode_q <= mode_stop;
				mode_stop: if (restart_cmd) mode_q <= mode_idle;
				default:   mode_q <= mode_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (rd) begin
			rdata_q <= rdata_d;
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rdata_q;
	assign mode       = mode_q;

endmodule

`default_nettype wire
